// File: hw/rv_lite_pkg.sv
package rv_lite_pkg;

  localparam int XLEN     = 32;
  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  // major opcodes kept from rv32i
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  localparam logic [2:0] F3_ADD  = 3'b000; // add, sub, addi
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // srl and sra share this
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_ALT = 7'b0100000; // sub, sra, srai

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SRL    = 4'd3,
    ALU_SRA    = 4'd4,
    ALU_AND    = 4'd5,
    ALU_OR     = 4'd6,
    ALU_XOR    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_PASS_B = 4'd10  // lui
  } alu_op_t;

  // one instruction word, two field layouts
  typedef union packed {
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r_fmt;
    struct packed {
      logic [19:0]       imm20;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } u_fmt;
  } inst_u;

endpackage

// File: hw/hex_digit.sv
module hex_digit (
  input  logic [3:0] nibble_i,
  output logic [6:0] seg_o
);

  // active high, segment a on bit 0
  always_comb begin
    case (nibble_i)
      4'h0:    seg_o = 7'b0111111;
      4'h1:    seg_o = 7'b0000110;
      4'h2:    seg_o = 7'b1011011;
      4'h3:    seg_o = 7'b1001111;
      4'h4:    seg_o = 7'b1100110;
      4'h5:    seg_o = 7'b1101101;
      4'h6:    seg_o = 7'b1111101;
      4'h7:    seg_o = 7'b0000111;
      4'h8:    seg_o = 7'b1111111;
      4'h9:    seg_o = 7'b1100111;
      4'ha:    seg_o = 7'b1110111;
      4'hb:    seg_o = 7'b1111100; // lower case b
      4'hc:    seg_o = 7'b0111001;
      4'hd:    seg_o = 7'b1011110; // lower case d
      4'he:    seg_o = 7'b1111001;
      default: seg_o = 7'b1110001; // f
    endcase
  end

endmodule

// File: hw/reg_file.sv
module reg_file import rv_lite_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [REG_AW-1:0] rs1_i,
  input  logic [REG_AW-1:0] rs2_i,
  input  logic [REG_AW-1:0] rd_i,
  input  logic              we_i,
  input  logic [XLEN-1:0]   wdata_i,
  output logic [XLEN-1:0]   rdata1_o,
  output logic [XLEN-1:0]   rdata2_o
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // x0 is never written, so it reads zero after reset
  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

endmodule

// File: hw/alu.sv
module alu import rv_lite_pkg::*; (
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic            use_imm_i,
  input  alu_op_t         op_i,
  output logic [XLEN-1:0] result_o
);

  logic [XLEN-1:0] opb;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;

  assign opb   = use_imm_i ? imm_i : b_i;
  assign shamt = opb[4:0]; // only the low five bits shift

  // real compares, no flag arithmetic
  assign lt_signed   = $signed(a_i) < $signed(opb);
  assign lt_unsigned = a_i < opb;

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + opb;
      ALU_SUB:    result_o = a_i - opb;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_AND:    result_o = a_i & opb;
      ALU_OR:     result_o = a_i | opb;
      ALU_XOR:    result_o = a_i ^ opb;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_PASS_B: result_o = opb;
      default:    result_o = '0;
    endcase
  end

endmodule

// File: hw/inst_decoder.sv
module inst_decoder import rv_lite_pkg::*; (
  input  inst_u             instr_i,
  output logic [REG_AW-1:0] rs1_o,
  output logic [REG_AW-1:0] rs2_o,
  output logic [REG_AW-1:0] rd_o,
  output logic [XLEN-1:0]   imm_o,
  output alu_op_t           alu_op_o,
  output logic              use_imm_o,
  output logic              reg_write_o,
  output logic              auipc_o
);

  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_u_type;
  logic            f7_alt;

  // funct3 to alu op, shared by register and immediate forms
  function automatic alu_op_t map_f3(input logic [2:0] f3, input logic sub_en,
                                     input logic sra_en);
    alu_op_t op;
    case (f3)
      F3_ADD:  op = sub_en ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = sra_en ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  // register fields sit at the same place in every kept format
  assign rs1_o = instr_i.r_fmt.rs1;
  assign rs2_o = instr_i.r_fmt.rs2;
  assign rd_o  = instr_i.r_fmt.rd;

  // i-type immediate is funct7 and rs2 of the r view, sign extended
  assign imm_i_type = {{(XLEN-12){instr_i.r_fmt.funct7[6]}},
                       instr_i.r_fmt.funct7, instr_i.r_fmt.rs2};
  assign imm_u_type = {instr_i.u_fmt.imm20, 12'b0};

  assign f7_alt = (instr_i.r_fmt.funct7 == F7_ALT);

  always_comb begin
    imm_o       = imm_i_type;
    alu_op_o    = ALU_ADD;
    use_imm_o   = 1'b0;
    reg_write_o = 1'b0; // unsupported opcodes only move the pc
    auipc_o     = 1'b0;
    case (instr_i.r_fmt.opcode)
      OPC_OP: begin
        alu_op_o    = map_f3(instr_i.r_fmt.funct3, f7_alt, f7_alt);
        reg_write_o = 1'b1;
      end
      OPC_OP_IMM: begin
        // no subi, funct7 only matters for srai
        alu_op_o    = map_f3(instr_i.r_fmt.funct3, 1'b0, f7_alt);
        use_imm_o   = 1'b1;
        reg_write_o = 1'b1;
      end
      OPC_LUI: begin
        imm_o       = imm_u_type;
        alu_op_o    = ALU_PASS_B;
        use_imm_o   = 1'b1;
        reg_write_o = 1'b1;
      end
      OPC_AUIPC: begin
        imm_o       = imm_u_type; // added to the pc in the core
        reg_write_o = 1'b1;
        auipc_o     = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: hw/exec_core.sv
module exec_core import rv_lite_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  output logic [XLEN-1:0] result_o,
  output logic [XLEN-1:0] pc_o
);

  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   imm;
  alu_op_t           alu_op;
  logic              use_imm;
  logic              reg_write;
  logic              auipc;
  logic [XLEN-1:0]   rdata1;
  logic [XLEN-1:0]   rdata2;
  logic [XLEN-1:0]   alu_result;
  logic [XLEN-1:0]   wb_data;
  logic              wb_en;
  logic [XLEN-1:0]   pc_q;
  logic [XLEN-1:0]   result_q;

  inst_decoder u_dec (
    .instr_i     (inst_u'(instr_i)),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .rd_o        (rd),
    .imm_o       (imm),
    .alu_op_o    (alu_op),
    .use_imm_o   (use_imm),
    .reg_write_o (reg_write),
    .auipc_o     (auipc)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rd_i     (rd),
    .we_i     (wb_en),
    .wdata_i  (wb_data),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  alu u_alu (
    .a_i       (rdata1),
    .b_i       (rdata2),
    .imm_i     (imm),
    .use_imm_i (use_imm),
    .op_i      (alu_op),
    .result_o  (alu_result)
  );

  assign wb_data = auipc ? (pc_q + imm) : alu_result;
  assign wb_en   = instr_valid_i & reg_write; // only on the strobe

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q     <= RESET_PC;
      result_q <= '0;
    end else if (instr_valid_i) begin
      pc_q <= pc_q + XLEN'(4);
      if (reg_write) result_q <= wb_data; // x0 writes still show here
    end
  end

  assign result_o = result_q;
  assign pc_o     = pc_q;

endmodule

// File: hw/rv_lite_top.sv
module rv_lite_top import rv_lite_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC   = '0,
  parameter int              NUM_DIGITS = 8
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        instr_valid_i,
  input  logic [XLEN-1:0]             instr_i,
  output logic [7:0]                  left_o,
  output logic [7:0]                  right_o,
  output logic [NUM_DIGITS-1:0][6:0]  ss_o
);

  logic [XLEN-1:0] result;
  logic [XLEN-1:0] pc;

  exec_core #(.RESET_PC(RESET_PC)) u_core (
    .clk           (clk),
    .rst           (rst),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .result_o      (result),
    .pc_o          (pc)
  );

  assign left_o  = pc[7:0];
  assign right_o = result[7:0];

  // digit i shows nibble i of the result
  for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
    hex_digit u_digit (
      .nibble_i (result[4*i +: 4]),
      .seg_o    (ss_o[i])
    );
  end

endmodule

// File: testbench/rv_lite_asserts.sv
module rv_lite_asserts import rv_lite_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic            instr_valid_i,
  input logic [XLEN-1:0] pc_i,
  input logic [XLEN-1:0] result_i
);

  // pc moves by exactly 4 per strobe
  pc_step: assert property (@(posedge clk) disable iff (rst)
    instr_valid_i |=> pc_i == $past(pc_i) + 32'd4)
    else $error("pc did not advance by 4 after a strobe");

  pc_hold: assert property (@(posedge clk) disable iff (rst)
    !instr_valid_i |=> $stable(pc_i))
    else $error("pc changed without a strobe");

  result_hold: assert property (@(posedge clk) disable iff (rst)
    !instr_valid_i |=> $stable(result_i))
    else $error("result register changed without a strobe");

endmodule

bind exec_core rv_lite_asserts u_asserts (
  .clk           (clk),
  .rst           (rst),
  .instr_valid_i (instr_valid_i),
  .pc_i          (pc_q),
  .result_i      (result_q)
);

// File: testbench/tb_rv_lite.sv
module tb_rv_lite
  import rv_lite_pkg::*;
();

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0040;
  localparam int NUM_INSTR = 2000;
  localparam int RESET_TIMEOUT = 20;

  // gfedcba, active high
  localparam logic [6:0] SEG_TAB [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h67, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
  };

  logic                clk = 1'b0;
  logic                rst;
  logic                instr_valid_i;
  logic [XLEN-1:0]     instr_i;
  logic [7:0]          left_o;
  logic [7:0]          right_o;
  logic [7:0][6:0]     ss_o;

  integer          seed = 32'h9d81ab23;
  int              errors;
  int              checks;
  logic [XLEN-1:0] mregs [NUM_REGS]; // reference register file
  logic [XLEN-1:0] mpc;
  logic [XLEN-1:0] mresult;

  rv_lite_top #(.RESET_PC(RESET_PC), .NUM_DIGITS(8)) dut (
    .clk           (clk),
    .rst           (rst),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .left_o        (left_o),
    .right_o       (right_o),
    .ss_o          (ss_o)
  );

  always #5 clk = ~clk;

  function automatic logic [XLEN-1:0] ref_op(input logic [2:0] f3, input logic sub_en,
                                             input logic sra_en, input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    case (f3)
      F3_ADD:  ref_op = sub_en ? a - b : a + b;
      F3_SLL:  ref_op = a << b[4:0];
      F3_SLT:  ref_op = {31'd0, $signed(a) < $signed(b)};
      F3_SLTU: ref_op = {31'd0, a < b};
      F3_XOR:  ref_op = a ^ b;
      F3_SR: begin
        sa = $signed(a) >>> b[4:0];
        ref_op = sra_en ? sa : a >> b[4:0];
      end
      F3_OR:   ref_op = a | b;
      default: ref_op = a & b;
    endcase
  endfunction

  task automatic model_exec(input logic [XLEN-1:0] w);
    inst_u           iw;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] res;
    logic            alt;
    logic            wr;
    iw  = w;
    a   = mregs[iw.r_fmt.rs1];
    imm = {{20{iw.r_fmt.funct7[6]}}, iw.r_fmt.funct7, iw.r_fmt.rs2};
    alt = (iw.r_fmt.funct7 == F7_ALT);
    wr  = 1'b1;
    res = '0;
    case (iw.r_fmt.opcode)
      OPC_OP:     res = ref_op(iw.r_fmt.funct3, alt, alt, a, mregs[iw.r_fmt.rs2]);
      OPC_OP_IMM: res = ref_op(iw.r_fmt.funct3, 1'b0, alt, a, imm); // no subi
      OPC_LUI:    res = {iw.u_fmt.imm20, 12'h000};
      OPC_AUIPC:  res = mpc + {iw.u_fmt.imm20, 12'h000};
      default:    wr = 1'b0;
    endcase
    if (wr) begin
      if (iw.r_fmt.rd != 5'd0) mregs[iw.r_fmt.rd] = res;
      mresult = res; // shown even for x0
    end
    mpc = mpc + 32'd4;
  endtask

  task automatic make_instr(output logic [XLEN-1:0] w);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  op;
    logic [11:0] imm12;
    r1 = $random(seed);
    r2 = $random(seed);
    f3 = r1[6:4];
    // mostly x0..x7 so results get reused
    rd  = r1[7] ? r1[12:8] : {2'b00, r1[10:8]};
    rs1 = r1[13] ? r1[18:14] : {2'b00, r1[16:14]};
    rs2 = r1[19] ? r1[24:20] : {2'b00, r1[22:20]};
    f7  = ((f3 == F3_ADD || f3 == F3_SR) && r1[25]) ? F7_ALT : 7'd0;
    imm12 = r2[11:0];
    if (r1[3:0] < 4'd5) begin
      w = {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (r1[3:0] < 4'd10) begin
      if (f3 == F3_SLL) imm12 = {7'd0, r2[4:0]};
      else if (f3 == F3_SR) imm12 = {(r1[25] ? F7_ALT : 7'd0), r2[4:0]};
      w = {imm12, rs1, f3, rd, OPC_OP_IMM};
    end else if (r1[3:0] < 4'd12) begin
      w = {r2[31:12], rd, OPC_LUI};
    end else if (r1[3:0] < 4'd14) begin
      w = {r2[31:12], rd, OPC_AUIPC};
    end else begin
      op = r2[6:0];
      // bit 6 flip moves a kept opcode off the supported set
      if (op == OPC_OP || op == OPC_OP_IMM || op == OPC_LUI || op == OPC_AUIPC)
        op = op ^ 7'h40;
      w = {r2[31:7], op};
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] got_v);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp_v, got_v);
    end
  endtask

  task automatic check_outputs();
    check_val("left_o", {24'h0, mpc[7:0]}, {24'h0, left_o});
    check_val("right_o", {24'h0, mresult[7:0]}, {24'h0, right_o});
    for (int i = 0; i < 8; i++) begin
      check_val($sformatf("ss_o[%0d]", i), {25'h0, SEG_TAB[mresult[4*i +: 4]]},
                {25'h0, ss_o[i]});
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  // drive on the rising edge, compare at the falling edge
  task automatic step(input logic valid, input logic [XLEN-1:0] word);
    @(posedge clk);
    instr_valid_i <= valid;
    instr_i       <= word;
    @(negedge clk);
    check_outputs();
    if (valid) model_exec(word);
  endtask

  task automatic wait_reset_release(output logic ok);
    int cnt;
    cnt = 0;
    while ((rst !== 1'b0 || right_o !== 8'h00) && cnt < RESET_TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    ok = (rst === 1'b0 && right_o === 8'h00);
    if (!ok) begin
      errors++;
      $display("outputs did not settle after reset within %0d cycles", RESET_TIMEOUT);
    end
  endtask

  initial begin
    logic [31:0] junk;
    logic [31:0] word;
    logic        reset_ok;
    rst           = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    errors        = 0;
    checks        = 0;
    mpc           = RESET_PC;
    mresult       = '0;
    for (int i = 0; i < NUM_REGS; i++) mregs[i] = '0;
    for (int i = 0; i < 8; i++) @(posedge clk);
    rst <= 1'b0;
    wait_reset_release(reset_ok);
    if (reset_ok) begin
      step(1'b0, '0); // reset state on the outputs
      for (int n = 0; n < NUM_INSTR; n++) begin
        junk = $random(seed);
        if (junk[1:0] == 2'b00) begin
          for (int k = 0; k <= int'(junk[3:2]); k++) step(1'b0, junk);
        end
        make_instr(word);
        step(1'b1, word);
      end
      step(1'b0, '0); // last strobe lands here
    end
    finish_run();
  end

endmodule

// File: rv_lite.f
hw/rv_lite_pkg.sv
hw/hex_digit.sv
hw/reg_file.sv
hw/alu.sv
hw/inst_decoder.sv
hw/exec_core.sv
hw/rv_lite_top.sv
testbench/rv_lite_asserts.sv
testbench/tb_rv_lite.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_lite
FILELIST  ?= rv_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM      := $(BUILD_DIR)/V$(TOP)
FAIL_MSG := *** FAILED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
